//--- axi_interface_spi.sv
`include "spi_cfg.svh"

module axi_interface_spi (
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  spi_pkg::addr_t      s_axi_araddr_i,
   input  logic                s_axi_arvalid_i,
   output logic                s_axi_arready_o,
   output spi_pkg::data_t      s_axi_rdata_o,
   output logic [1:0]          s_axi_rresp_o,
   output logic                s_axi_rvalid_o,
   input  logic                s_axi_rready_i,
   input  spi_pkg::addr_t      s_axi_awaddr_i,
   input  logic                s_axi_awvalid_i,
   output logic                s_axi_awready_o,
   input  spi_pkg::data_t      s_axi_wdata_i,
   input  logic [3:0]          s_axi_wstrb_i,
   input  logic                s_axi_wvalid_i,
   output logic                s_axi_wready_o,
   output logic [1:0]          s_axi_bresp_o,
   output logic                s_axi_bvalid_o,
   input  logic                s_axi_bready_i,
   output spi_pkg::reg_req_t   req_o,
   output logic                req_stb_o,
   input  logic                ack_i,
   input  spi_pkg::reg_rsp_t   rsp_i
);

   spi_pkg::axi_state_t state_q;
   logic                is_wr_q;
   logic                err_q;
   spi_pkg::data_t      rdata_q;
   spi_pkg::reg_req_t   req_q;

   logic                wr_pair;
   logic                wr_go;
   logic                rd_go;
   spi_pkg::addr_t      sel_addr;
   spi_pkg::reg_off_t   sel_off;
   logic                in_region;
   logic                off_bad;
   logic                strb_ok;
   logic                dir_bad;
   logic                dec_err;
   spi_pkg::xfer_size_t dec_size;

   // write wins when both channels arrive together
   assign wr_pair = s_axi_awvalid_i && s_axi_wvalid_i;
   assign wr_go   = (state_q == spi_pkg::AXI_IDLE) && wr_pair;
   assign rd_go   = (state_q == spi_pkg::AXI_IDLE) && !wr_pair && s_axi_arvalid_i;

   assign sel_addr  = wr_pair ? s_axi_awaddr_i : s_axi_araddr_i;
   assign sel_off   = sel_addr[4:0];
   assign in_region = (sel_addr & ~`SPI_ADDR_MASK) == `SPI_BASE_ADDR;
   // full byte offset, so 20 hex does not alias onto CTRL
   assign off_bad   = (sel_addr & `SPI_ADDR_MASK) > {27'd0, `SPI_CS_OFF};

   assign strb_ok  = (s_axi_wstrb_i == 4'b0001) || (s_axi_wstrb_i == 4'b0011) ||
                     (s_axi_wstrb_i == 4'b1111);
   assign dec_size = {s_axi_wstrb_i[3], s_axi_wstrb_i[1]};

   always_comb begin
      if (wr_pair) begin
         dir_bad = (sel_off == `SPI_STAT_OFF) || (sel_off == `SPI_RDATA_OFF) ||
                   ((sel_off == `SPI_TDATA_OFF) && !strb_ok);
      end else begin
         dir_bad = (sel_off == `SPI_TDATA_OFF);
      end
   end

   assign dec_err = !in_region || off_bad || dir_bad;

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         state_q <= spi_pkg::AXI_IDLE;
         is_wr_q <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            spi_pkg::AXI_IDLE: begin
               if (wr_go || rd_go) begin
                  is_wr_q <= wr_go;
                  err_q   <= dec_err;
                  // decode errors skip the internal bus
                  state_q <= dec_err ? spi_pkg::AXI_RESP : spi_pkg::AXI_REQ;
               end
            end
            spi_pkg::AXI_REQ: begin
               if (ack_i) begin
                  err_q   <= rsp_i.err;
                  state_q <= spi_pkg::AXI_RESP;
               end
            end
            spi_pkg::AXI_RESP: begin
               if (is_wr_q ? s_axi_bready_i : s_axi_rready_i) begin
                  state_q <= spi_pkg::AXI_IDLE;
               end
            end
            default: state_q <= spi_pkg::AXI_IDLE;
         endcase
      end
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (wr_go || rd_go) begin
         req_q.off   <= sel_off;
         req_q.wr    <= wr_go;
         req_q.wdata <= s_axi_wdata_i;
         req_q.size  <= wr_go ? dec_size : `SPI_SIZE_WORD;
         rdata_q     <= '0;
      end else if ((state_q == spi_pkg::AXI_REQ) && ack_i) begin
         rdata_q <= rsp_i.rdata;
      end
   end

   assign s_axi_awready_o = wr_go;
   assign s_axi_wready_o  = wr_go;
   assign s_axi_arready_o = rd_go;

   assign s_axi_bvalid_o = (state_q == spi_pkg::AXI_RESP) && is_wr_q;
   assign s_axi_rvalid_o = (state_q == spi_pkg::AXI_RESP) && !is_wr_q;
   assign s_axi_bresp_o  = err_q ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
   assign s_axi_rresp_o  = err_q ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
   assign s_axi_rdata_o  = rdata_q;

   assign req_stb_o = (state_q == spi_pkg::AXI_REQ);
   assign req_o     = req_q;

   // wishbone classic: request held steady until ack
   a_stb_hold: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      req_stb_o && !ack_i |=> req_stb_o && $stable(req_o))
      else $error("stb dropped or request changed before ack");

   a_one_resp: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      !(s_axi_bvalid_o && s_axi_rvalid_o))
      else $error("bvalid and rvalid high together");

   a_b_stable: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bresp_o))
      else $error("write response changed while stalled");

   a_r_stable: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      s_axi_rvalid_o && !s_axi_rready_i |=>
      s_axi_rvalid_o && $stable(s_axi_rresp_o) && $stable(s_axi_rdata_o))
      else $error("read response changed while stalled");

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the SPI subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_spi_subsystem \
   -f sim.f

./obj_dir/Vtb_spi_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
   exit 0
fi
exit 1

//--- sim.f
+incdir+.
spi_pkg.sv
axi_interface_spi.sv
spi_regs.sv
spi_shifter.sv
spi_subsystem_top.sv
tb_spi_subsystem.sv

//--- spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// spi register region on the axi bus
`define SPI_BASE_ADDR   32'h2001_0000
`define SPI_ADDR_MASK   32'h0000_00FF

// register offsets inside the region
`define SPI_CTRL_OFF    5'h00
`define SPI_STAT_OFF    5'h04
`define SPI_RDATA_OFF   5'h08
`define SPI_TDATA_OFF   5'h0C
`define SPI_CS_OFF      5'h10

// transfer size codes, built from strobe bits 3 and 1
`define SPI_SIZE_BYTE   2'b00
`define SPI_SIZE_HALF   2'b01
`define SPI_SIZE_WORD   2'b11

// axi response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

//--- spi_pkg.sv
package spi_pkg;

   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [4:0]  reg_off_t;
   typedef logic [1:0]  xfer_size_t;
   typedef logic [7:0]  clk_div_t;
   // bits left in a transfer, up to 32
   typedef logic [5:0]  bit_cnt_t;

   typedef enum logic [1:0] {
      AXI_IDLE,
      AXI_REQ,
      AXI_RESP
   } axi_state_t;

   typedef enum logic [1:0] {
      SH_IDLE,
      SH_SHIFT,
      SH_FINISH
   } shift_state_t;

   // front end to register block
   typedef struct packed {
      reg_off_t   off;
      logic       wr;
      data_t      wdata;
      xfer_size_t size;
   } reg_req_t;

   typedef struct packed {
      data_t rdata;
      logic  err;
   } reg_rsp_t;

   // register block to shifter
   typedef struct packed {
      data_t      tx;
      xfer_size_t size;
      clk_div_t   div;
   } xfer_cmd_t;

endpackage

//--- spi_regs.sv
`include "spi_cfg.svh"

module spi_regs (
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  spi_pkg::reg_req_t   req_i,
   input  logic                req_stb_i,
   output logic                ack_o,
   output spi_pkg::reg_rsp_t   rsp_o,
   output logic                start_o,
   output spi_pkg::xfer_cmd_t  cmd_o,
   input  logic                busy_i,
   input  logic                done_i,
   input  spi_pkg::data_t      rx_data_i,
   output logic [3:0]          spi_cs_n_o
);

   logic                ctrl_en_q;
   spi_pkg::clk_div_t   ctrl_div_q;
   logic [3:0]          cs_q;
   logic                rx_valid_q;
   spi_pkg::data_t      rdata_q;

   logic                tdata_wr;
   logic                ctrl_wr;
   logic                cs_wr;
   logic                rdata_rd;

   assign tdata_wr = req_stb_i && req_i.wr && (req_i.off == `SPI_TDATA_OFF);
   assign ctrl_wr  = req_stb_i && req_i.wr && (req_i.off == `SPI_CTRL_OFF);
   assign cs_wr    = req_stb_i && req_i.wr && (req_i.off == `SPI_CS_OFF);
   assign rdata_rd = req_stb_i && !req_i.wr && (req_i.off == `SPI_RDATA_OFF);

   // hold off a transmit write until the shifter is free
   assign ack_o   = req_stb_i && !(tdata_wr && ctrl_en_q && busy_i);
   assign start_o = tdata_wr && ctrl_en_q && !busy_i;

   assign cmd_o.tx   = req_i.wdata;
   assign cmd_o.size = req_i.size;
   assign cmd_o.div  = ctrl_div_q;

   always_comb begin
      // transmit while disabled is refused
      rsp_o.err = tdata_wr && !ctrl_en_q;
      case (req_i.off)
         `SPI_CTRL_OFF:  rsp_o.rdata = {16'd0, ctrl_div_q, 7'd0, ctrl_en_q};
         `SPI_STAT_OFF:  rsp_o.rdata = {30'd0, rx_valid_q, busy_i};
         `SPI_RDATA_OFF: rsp_o.rdata = rdata_q;
         `SPI_CS_OFF:    rsp_o.rdata = {28'd0, cs_q};
         default:        rsp_o.rdata = '0;
      endcase
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         ctrl_en_q  <= 1'b0;
         ctrl_div_q <= '0;
         cs_q       <= '0;
         rx_valid_q <= 1'b0;
         rdata_q    <= '0;
      end else begin
         if (ctrl_wr) begin
            ctrl_en_q  <= req_i.wdata[0];
            ctrl_div_q <= req_i.wdata[15:8];
         end
         if (cs_wr) begin
            cs_q <= req_i.wdata[3:0];
         end
         // new data beats a clearing read in the same cycle
         if (done_i) begin
            rdata_q    <= rx_data_i;
            rx_valid_q <= 1'b1;
         end else if (rdata_rd) begin
            rx_valid_q <= 1'b0;
         end
      end
   end

   // register bits are active high, pins active low
   assign spi_cs_n_o = ~cs_q;

   a_start_idle: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      start_o |-> !busy_i ##1 busy_i)
      else $error("start issued while busy or shifter did not go busy");

endmodule

//--- spi_shifter.sv
`include "spi_cfg.svh"

module spi_shifter (
   input  logic                s_axi_aclk_i,
   input  logic                s_axi_aresetn_i,
   input  logic                start_i,
   input  spi_pkg::xfer_cmd_t  cmd_i,
   output logic                busy_o,
   output logic                done_o,
   output spi_pkg::data_t      rx_data_o,
   output logic                spi_sclk_o,
   output logic                spi_mosi_o,
   input  logic                spi_miso_i
);

   spi_pkg::shift_state_t state_q;
   spi_pkg::clk_div_t     div_q;
   spi_pkg::clk_div_t     div_cnt_q;
   spi_pkg::bit_cnt_t     bits_left_q;
   spi_pkg::data_t        tx_sr_q;
   spi_pkg::data_t        rx_sr_q;
   logic                  sclk_q;

   logic                  load;
   logic                  half_tick;
   spi_pkg::bit_cnt_t     load_bits;
   spi_pkg::data_t        load_word;

   // a new start may land in the finish cycle
   assign load      = start_i && (state_q != spi_pkg::SH_SHIFT);
   assign half_tick = (state_q == spi_pkg::SH_SHIFT) && (div_cnt_q == div_q);

   // left-align the low bytes so the msb sits at bit 31
   always_comb begin
      case (cmd_i.size)
         `SPI_SIZE_HALF: begin
            load_bits = 6'd16;
            load_word = {cmd_i.tx[15:0], 16'd0};
         end
         `SPI_SIZE_WORD: begin
            load_bits = 6'd32;
            load_word = cmd_i.tx;
         end
         default: begin
            load_bits = 6'd8;
            load_word = {cmd_i.tx[7:0], 24'd0};
         end
      endcase
   end

   always_ff @(posedge s_axi_aclk_i) begin
      if (!s_axi_aresetn_i) begin
         state_q     <= spi_pkg::SH_IDLE;
         div_cnt_q   <= '0;
         bits_left_q <= '0;
         sclk_q      <= 1'b0;
      end else if (load) begin
         state_q     <= spi_pkg::SH_SHIFT;
         div_cnt_q   <= '0;
         bits_left_q <= load_bits;
         sclk_q      <= 1'b0;
      end else begin
         case (state_q)
            spi_pkg::SH_SHIFT: begin
               if (half_tick) begin
                  div_cnt_q <= '0;
                  sclk_q    <= !sclk_q;
                  // falling edge closes one bit
                  if (sclk_q) begin
                     bits_left_q <= bits_left_q - 6'd1;
                     if (bits_left_q == 6'd1) begin
                        state_q <= spi_pkg::SH_FINISH;
                     end
                  end
               end else begin
                  div_cnt_q <= div_cnt_q + 8'd1;
               end
            end
            spi_pkg::SH_FINISH: state_q <= spi_pkg::SH_IDLE;
            default:            state_q <= spi_pkg::SH_IDLE;
         endcase
      end
   end

   // sample miso on rising sclk, shift mosi on falling
   always_ff @(posedge s_axi_aclk_i) begin
      if (load) begin
         tx_sr_q <= load_word;
         rx_sr_q <= '0;
         div_q   <= cmd_i.div;
      end else if (half_tick) begin
         if (!sclk_q) begin
            rx_sr_q <= {rx_sr_q[30:0], spi_miso_i};
         end else begin
            tx_sr_q <= {tx_sr_q[30:0], 1'b0};
         end
      end
   end

   assign busy_o     = (state_q == spi_pkg::SH_SHIFT);
   assign done_o     = (state_q == spi_pkg::SH_FINISH);
   assign rx_data_o  = rx_sr_q;
   assign spi_sclk_o = sclk_q;
   assign spi_mosi_o = (state_q == spi_pkg::SH_SHIFT) && tx_sr_q[31];

   a_sclk_idle: assert property (@(posedge s_axi_aclk_i) disable iff (!s_axi_aresetn_i)
      !busy_o |-> !spi_sclk_o)
      else $error("sclk high outside a transfer");

endmodule

//--- spi_subsystem_top.sv
module spi_subsystem_top (
   input  logic            s_axi_aclk_i,
   input  logic            s_axi_aresetn_i,
   input  spi_pkg::addr_t  s_axi_araddr_i,
   input  logic            s_axi_arvalid_i,
   output logic            s_axi_arready_o,
   output spi_pkg::data_t  s_axi_rdata_o,
   output logic [1:0]      s_axi_rresp_o,
   output logic            s_axi_rvalid_o,
   input  logic            s_axi_rready_i,
   input  spi_pkg::addr_t  s_axi_awaddr_i,
   input  logic            s_axi_awvalid_i,
   output logic            s_axi_awready_o,
   input  spi_pkg::data_t  s_axi_wdata_i,
   input  logic [3:0]      s_axi_wstrb_i,
   input  logic            s_axi_wvalid_i,
   output logic            s_axi_wready_o,
   output logic [1:0]      s_axi_bresp_o,
   output logic            s_axi_bvalid_o,
   input  logic            s_axi_bready_i,
   output logic            spi_sclk_o,
   output logic            spi_mosi_o,
   input  logic            spi_miso_i,
   output logic [3:0]      spi_cs_n_o
);

   spi_pkg::reg_req_t  req;
   logic               req_stb;
   logic               ack;
   spi_pkg::reg_rsp_t  rsp;
   logic               start;
   spi_pkg::xfer_cmd_t cmd;
   logic               busy;
   logic               done;
   spi_pkg::data_t     rx_data;

   axi_interface_spi u_axi (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rresp_o   (s_axi_rresp_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wstrb_i   (s_axi_wstrb_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bresp_o   (s_axi_bresp_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .req_o           (req),
      .req_stb_o       (req_stb),
      .ack_i           (ack),
      .rsp_i           (rsp)
   );

   spi_regs u_regs (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .req_i           (req),
      .req_stb_i       (req_stb),
      .ack_o           (ack),
      .rsp_o           (rsp),
      .start_o         (start),
      .cmd_o           (cmd),
      .busy_i          (busy),
      .done_i          (done),
      .rx_data_i       (rx_data),
      .spi_cs_n_o      (spi_cs_n_o)
   );

   spi_shifter u_shifter (
      .s_axi_aclk_i    (s_axi_aclk_i),
      .s_axi_aresetn_i (s_axi_aresetn_i),
      .start_i         (start),
      .cmd_i           (cmd),
      .busy_o          (busy),
      .done_o          (done),
      .rx_data_o       (rx_data),
      .spi_sclk_o      (spi_sclk_o),
      .spi_mosi_o      (spi_mosi_o),
      .spi_miso_i      (spi_miso_i)
   );

endmodule

//--- tb_spi_subsystem.sv
`include "spi_cfg.svh"

module tb_spi_subsystem;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_XFER = 24;
   // worst transfer is 32 bits of 2 x 256 cycles plus register traffic
   localparam int CYCLE_LIMIT = (NUM_XFER + 8) * 32 * 2 * 256 + 20000;

   logic clk;
   logic rstn;
   logic [31:0] araddr;
   logic arvalid;
   logic arready;
   logic [31:0] rdata;
   logic [1:0] rresp;
   logic rvalid;
   logic rready;
   logic [31:0] awaddr;
   logic awvalid;
   logic awready;
   logic [31:0] wdata;
   logic [3:0] wstrb;
   logic wvalid;
   logic wready;
   logic [1:0] bresp;
   logic bvalid;
   logic bready;
   logic sclk;
   logic mosi;
   logic miso;
   logic [3:0] cs_n;

   int err_cnt = 0;
   int chk_cnt = 0;
   int cyc = 0;
   logic [31:0] rng = 32'd30325;

   // register model
   logic m_en;
   logic [7:0] m_div;
   logic [3:0] m_cs;
   logic m_rxv;
   logic [31:0] m_rdata;

   // spi slave model state
   int unsigned sl_n_q[$];
   logic [31:0] sl_w_q[$];
   logic [31:0] cap_q[$];
   int unsigned sl_n;
   int unsigned sl_cnt;
   logic [31:0] sl_sr;
   logic [31:0] sl_cap;
   bit sl_active = 0;

   spi_subsystem_top uut (
      .s_axi_aclk_i(clk), .s_axi_aresetn_i(rstn),
      .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
      .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp), .s_axi_rvalid_o(rvalid),
      .s_axi_rready_i(rready),
      .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
      .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
      .s_axi_wready_o(wready),
      .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid), .s_axi_bready_i(bready),
      .spi_sclk_o(sclk), .spi_mosi_o(mosi), .spi_miso_i(miso), .spi_cs_n_o(cs_n)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cyc++;
      if (cyc > CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [31:0] size_mask(int unsigned n);
      return (n == 32) ? 32'hFFFF_FFFF : ((32'h1 << n) - 32'h1);
   endfunction

   function automatic logic [31:0] reg_addr(logic [4:0] off);
      return `SPI_BASE_ADDR | {27'd0, off};
   endfunction

   task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
      chk_cnt++;
      assert (got === exp) else begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         err_cnt++;
      end
   endtask

   // slave picks up the next queued word once the bus is quiet
   task automatic slave_next();
      if (!sl_active && sl_n_q.size() > 0) begin
         sl_n = sl_n_q.pop_front();
         sl_sr = sl_w_q.pop_front() << (32 - sl_n);
         sl_cnt = 0;
         sl_cap = '0;
         sl_active = 1;
         miso <= #1 sl_sr[31];
      end
   endtask

   always @(posedge sclk) begin
      if (sl_active) begin
         chk_cnt++;
         assert (cs_n != 4'hF) else begin
            $display("sclk toggled with no chip select active");
            err_cnt++;
         end
         sl_cap = {sl_cap[30:0], mosi};
         sl_cnt++;
         if (sl_cnt == sl_n) begin
            cap_q.push_back(sl_cap);
            sl_active = 0;
         end
      end
   end

   always @(negedge sclk) begin
      if (sl_active) begin
         sl_sr = sl_sr << 1;
         miso <= #1 sl_sr[31];
      end else begin
         slave_next();
      end
   end

   // all tasks start and end 1 ns after a rising edge
   task automatic axi_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb,
                            output logic [1:0] resp);
      int hold;
      hold = next_rand() % 4;
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awvalid = 1;
      wvalid = 1;
      do @(negedge clk); while (!(awready && wready));
      @(posedge clk);
      #1;
      awvalid = 0;
      wvalid = 0;
      do @(negedge clk); while (!bvalid);
      resp = bresp;
      repeat (hold) begin
         @(negedge clk);
         check_val("bresp", {30'd0, bresp}, {30'd0, resp});
         check_val("bvalid", {31'd0, bvalid}, 32'd1);
      end
      @(posedge clk);
      #1;
      bready = 1;
      @(posedge clk);
      #1;
      bready = 0;
   endtask

   task automatic axi_read(logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int hold;
      hold = next_rand() % 4;
      araddr = addr;
      arvalid = 1;
      do @(negedge clk); while (!arready);
      @(posedge clk);
      #1;
      arvalid = 0;
      do @(negedge clk); while (!rvalid);
      resp = rresp;
      data = rdata;
      repeat (hold) begin
         @(negedge clk);
         check_val("rresp", {30'd0, rresp}, {30'd0, resp});
         check_val("rdata", rdata, data);
      end
      @(posedge clk);
      #1;
      rready = 1;
      @(posedge clk);
      #1;
      rready = 0;
   endtask

   task automatic write_ok(logic [4:0] off, logic [31:0] data, logic [3:0] strb);
      logic [1:0] resp;
      axi_write(reg_addr(off), data, strb, resp);
      check_val("bresp", {30'd0, resp}, {30'd0, `AXI_RESP_OKAY});
   endtask

   task automatic read_expect(string name, logic [4:0] off, logic [31:0] exp);
      logic [31:0] data;
      logic [1:0] resp;
      axi_read(reg_addr(off), data, resp);
      check_val({name, " rresp"}, {30'd0, resp}, {30'd0, `AXI_RESP_OKAY});
      check_val(name, data, exp);
   endtask

   task automatic write_err(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
      logic [1:0] resp;
      axi_write(addr, data, strb, resp);
      check_val("bresp", {30'd0, resp}, {30'd0, `AXI_RESP_SLVERR});
   endtask

   task automatic check_model();
      read_expect("ctrl", `SPI_CTRL_OFF, {16'd0, m_div, 7'd0, m_en});
      read_expect("cs", `SPI_CS_OFF, {28'd0, m_cs});
      read_expect("stat", `SPI_STAT_OFF, {30'd0, m_rxv, 1'b0});
      read_expect("rdata", `SPI_RDATA_OFF, m_rdata);
      m_rxv = 0;
      check_val("cs_n", {28'd0, cs_n}, {28'd0, ~m_cs});
   endtask

   task automatic set_ctrl(logic en, logic [7:0] div);
      write_ok(`SPI_CTRL_OFF, {next_rand() & 32'hFFFF_0000} | {16'd0, div, 7'd0, en}, 4'hF);
      m_en = en;
      m_div = div;
   endtask

   task automatic pick_size(output logic [3:0] strb, output int unsigned n);
      case (next_rand() % 3)
         0: begin
            strb = 4'b0001;
            n = 8;
         end
         1: begin
            strb = 4'b0011;
            n = 16;
         end
         default: begin
            strb = 4'b1111;
            n = 32;
         end
      endcase
   endtask

   // one transfer with status polling and readback
   task automatic run_xfer();
      logic [3:0] strb;
      int unsigned n;
      logic [31:0] tx;
      logic [31:0] sw;
      logic [31:0] st;
      logic [1:0] resp;
      pick_size(strb, n);
      tx = next_rand();
      sw = next_rand();
      set_ctrl(1'b1, 8'(1 + next_rand() % 3));
      sl_n_q.push_back(n);
      sl_w_q.push_back(sw);
      slave_next();
      write_ok(`SPI_TDATA_OFF, tx, strb);
      read_expect("stat busy", `SPI_STAT_OFF, 32'h1);
      do axi_read(reg_addr(`SPI_STAT_OFF), st, resp); while (st[1] == 1'b0);
      check_val("stat", st, 32'h2);
      m_rxv = 1;
      m_rdata = sw & size_mask(n);
      read_expect("stat", `SPI_STAT_OFF, 32'h2);
      read_expect("rdata", `SPI_RDATA_OFF, m_rdata);
      m_rxv = 0;
      read_expect("stat", `SPI_STAT_OFF, 32'h0);
      check_val("mosi count", cap_q.size(), 1);
      if (cap_q.size() > 0) begin
         check_val("mosi word", cap_q.pop_front(), tx & size_mask(n));
      end
   endtask

   task automatic run_back_pressure();
      logic [3:0] strb1;
      logic [3:0] strb2;
      int unsigned n1;
      int unsigned n2;
      logic [31:0] tx1;
      logic [31:0] tx2;
      logic [31:0] sw1;
      logic [31:0] sw2;
      logic [31:0] st;
      logic [1:0] resp;
      pick_size(strb1, n1);
      pick_size(strb2, n2);
      tx1 = next_rand();
      tx2 = next_rand();
      sw1 = next_rand();
      sw2 = next_rand();
      set_ctrl(1'b1, 8'(next_rand() % 3));
      sl_n_q.push_back(n1);
      sl_w_q.push_back(sw1);
      sl_n_q.push_back(n2);
      sl_w_q.push_back(sw2);
      slave_next();
      write_ok(`SPI_TDATA_OFF, tx1, strb1);
      write_ok(`SPI_TDATA_OFF, tx2, strb2);
      // second response only after the first word completed
      check_val("first xfer done", {31'd0, cap_q.size() >= 1}, 32'd1);
      m_rxv = 1;
      read_expect("stat second busy", `SPI_STAT_OFF, {30'd0, m_rxv, 1'b1});
      do axi_read(reg_addr(`SPI_STAT_OFF), st, resp); while (st[0] == 1'b1);
      m_rdata = sw2 & size_mask(n2);
      check_val("mosi count", cap_q.size(), 2);
      if (cap_q.size() == 2) begin
         check_val("mosi word 1", cap_q.pop_front(), tx1 & size_mask(n1));
         check_val("mosi word 2", cap_q.pop_front(), tx2 & size_mask(n2));
      end
      check_model();
   endtask

   initial begin
      logic [31:0] d;
      logic [31:0] st;
      logic [1:0] resp;
      clk = 0;
      rstn = 0;
      araddr = '0;
      arvalid = 0;
      rready = 0;
      awaddr = '0;
      awvalid = 0;
      wdata = '0;
      wstrb = '0;
      wvalid = 0;
      bready = 0;
      miso = 0;
      m_en = 0;
      m_div = '0;
      m_cs = '0;
      m_rxv = 0;
      m_rdata = '0;
      repeat (5) @(posedge clk);
      #1;
      rstn = 1;
      check_model();

      // readback of ctrl and cs
      repeat (8) begin
         d = next_rand();
         write_ok(`SPI_CTRL_OFF, d, 4'hF);
         m_en = d[0];
         m_div = d[15:8];
         d = next_rand();
         write_ok(`SPI_CS_OFF, d, 4'hF);
         m_cs = d[3:0];
         check_model();
      end

      m_cs = 4'(1 + next_rand() % 15);
      write_ok(`SPI_CS_OFF, {28'd0, m_cs}, 4'hF);
      for (int i = 0; i < NUM_XFER; i++) begin
         run_xfer();
      end

      // error decode
      write_err(`SPI_BASE_ADDR + 32'h0001_0000, next_rand(), 4'hF);
      write_err(`SPI_BASE_ADDR | 32'h20, next_rand(), 4'hF);
      write_err(reg_addr(`SPI_STAT_OFF), next_rand(), 4'hF);
      write_err(reg_addr(`SPI_RDATA_OFF), next_rand(), 4'hF);
      axi_read(reg_addr(`SPI_TDATA_OFF), d, resp);
      check_val("rresp", {30'd0, resp}, {30'd0, `AXI_RESP_SLVERR});
      axi_read(`SPI_BASE_ADDR | 32'h20, d, resp);
      check_val("rresp", {30'd0, resp}, {30'd0, `AXI_RESP_SLVERR});
      write_err(reg_addr(`SPI_TDATA_OFF), next_rand(), 4'b0101);
      check_model();
      set_ctrl(1'b0, m_div);
      write_err(reg_addr(`SPI_TDATA_OFF), next_rand(), 4'hF);
      axi_read(reg_addr(`SPI_STAT_OFF), st, resp);
      check_val("stat after refused write", st, 32'h0);
      check_val("mosi count", cap_q.size(), 0);
      check_model();

      repeat (4) begin
         run_back_pressure();
      end

      repeat (10) @(posedge clk);
      $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
